/* filelist.f */
+incdir+include
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/inst_issue_queue.sv
rtl/ex_ctrl_decode.sv
rtl/mem_ctrl_decode.sv
rtl/wb_ctrl_decode.sv
rtl/ctrl_pipe.sv
rtl/control_unit_top.sv
verif/control_unit_assertions.sv
verif/control_unit_checker.sv
verif/control_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module control_unit_tb -Mdir obj_dir

./obj_dir/Vcontrol_unit_tb | tee sim.log

# pass only if the testbench reported it
grep -q "All checks passed" sim.log

/* verif/control_unit_tb.sv */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module control_unit_tb;
	localparam int TABLE_LEN = 17;
	localparam int TIMEOUT_CYCLES = 4 * TABLE_LEN + 40;
	localparam logic [31:0] LFSR_SEED = 32'hd96d_52ac;

	// each row holds word, {stall, flush, mem_wait}, ex ctrl, mem ctrl and {wb ctrl, new inst}
	localparam logic [33:0] STEPS [TABLE_LEN] = '{
		{16'hF6C0, 3'b000, 2'b01, 5'b00000, 8'b10011001},
		{16'hF847, 3'b000, 2'b01, 5'b00000, 8'b10001001},
		{16'h4105, 3'b100, 2'b10, 5'b00000, 8'b10001001},
		{16'h57FF, 3'b000, 2'b10, 5'b00000, 8'b10011001},
		{16'h6212, 3'b001, 2'b10, 5'b00000, 8'b11110001},
		{16'h7604, 3'b001, 2'b10, 5'b10000, 8'b10110001},
		{16'h8B08, 3'b000, 2'b10, 5'b01000, 8'b00000001},
		{16'h0603, 3'b010, 2'b00, 5'b00100, 8'b00000001},
		{16'h2402, 3'b000, 2'b10, 5'b00100, 8'b00000001},
		{16'h9123, 3'b000, 2'b00, 5'b00010, 8'b00000001},
		{16'hA0F0, 3'b110, 2'b00, 5'b00010, 8'b11010001},
		{16'hFC19, 3'b000, 2'b00, 5'b00011, 8'b00000001},
		{16'hF41A, 3'b011, 2'b00, 5'b00011, 8'b11010001},
		{16'hF81C, 3'b010, 2'b00, 5'b00000, 8'b00000011},
		// nop retires nothing
		{16'h0000, 3'b000, 2'b00, 5'b00000, 8'b00000000},
		{16'hF181, 3'b100, 2'b01, 5'b00000, 8'b10010001},
		{16'hF01D, 3'b000, 2'b00, 5'b00000, 8'b00000101}
	};

	logic reset_n;
	logic reset;
	logic inst_valid;
	logic [`CU_WORD_SIZE-1:0] inst_in;
	logic stall;
	logic flush;
	logic mem_wait;
	logic credit_return;
	logic ex_alu_src_b;
	logic ex_alu_op;
	logic m_mem_read;
	logic m_mem_write;
	logic m_pc_br;
	logic m_pc_j;
	logic m_pc_jr;
	logic wb_reg_write;
	logic [1:0] wb_src;
	logic [1:0] wb_dest;
	logic wb_halt;
	logic wb_wwd;
	logic wb_new_inst;
	logic [14:0] exp_ctrl;
	int ex_errors;
	int m_errors;
	int wb_errors;
	int credit_errors;
	logic [`CU_CREDIT_W-1:0] credits;
	int cycles = 0;
	logic [31:0] lfsr;

	control_unit_top u_dut (.*);

	control_unit_checker u_checker (.*);

	initial begin
		reset_n = 1'b0;
		forever #4 reset_n = ~reset_n;
	end

	always @(posedge reset_n) cycles <= cycles + 1;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// drive one cycle from the falling edge and pick up returned credits
	task automatic drive_cycle(input logic valid, input logic [15:0] word,
			input logic [2:0] ctl, input logic [14:0] exp);
		inst_valid = valid;
		inst_in = word;
		{stall, flush, mem_wait} = ctl;
		exp_ctrl = exp;
		if (valid) begin
			credits--;
		end
		@(negedge reset_n);
		if (credit_return) begin
			credits++;
		end
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 16'h0000, 3'b000, 15'd0);
	endtask

	initial begin
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_in = '0;
		stall = 1'b0;
		flush = 1'b0;
		mem_wait = 1'b0;
		exp_ctrl = '0;
		credits = `CU_CREDIT_W'(`CU_QUEUE_DEPTH);
		lfsr = LFSR_SEED;
		repeat (4) @(negedge reset_n);
		reset = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			lfsr = lfsr_step(lfsr);
			if (lfsr[0]) begin
				idle_cycle();
			end
			while (credits == 0) begin
				idle_cycle();
			end
			drive_cycle(1'b1, STEPS[i][33:18], STEPS[i][17:15], STEPS[i][14:0]);
		end
		// every credit back means every word has issued
		while (credits != `CU_CREDIT_W'(`CU_QUEUE_DEPTH)) begin
			idle_cycle();
		end
		// pipe drains
		repeat (4) idle_cycle();
		@(posedge reset_n);
		$display("errors: ex %0d, m %0d, wb %0d, credit %0d",
			ex_errors, m_errors, wb_errors, credit_errors);
		if (ex_errors + m_errors + wb_errors + credit_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

/* verif/control_unit_checker.sv */
`timescale 1ns/1ps

module control_unit_checker (
	input  logic        reset_n,
	input  logic        reset,
	input  logic        inst_valid,
	input  logic [14:0] exp_ctrl,
	input  logic        stall,
	input  logic        flush,
	input  logic        mem_wait,
	input  logic        credit_return,
	input  logic        ex_alu_src_b,
	input  logic        ex_alu_op,
	input  logic        m_mem_read,
	input  logic        m_mem_write,
	input  logic        m_pc_br,
	input  logic        m_pc_j,
	input  logic        m_pc_jr,
	input  logic        wb_reg_write,
	input  logic [1:0]  wb_src,
	input  logic [1:0]  wb_dest,
	input  logic        wb_halt,
	input  logic        wb_wwd,
	input  logic        wb_new_inst,
	output int          ex_errors = 0,
	output int          m_errors = 0,
	output int          wb_errors = 0,
	output int          credit_errors = 0
);
	// expected control words waiting in the queue
	logic [14:0] queue [$];
	logic [14:0] st_ex;
	logic [14:0] st_m;
	logic [14:0] st_wb;
	logic exp_credit;
	logic do_pop;
	logic started = 1'b0;

	function automatic int mismatch(input string name, input logic [1:0] got,
			input logic [1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
			return 1;
		end
		return 0;
	endfunction

	always @(posedge reset_n) begin
		if (reset) begin
			queue.delete();
			st_ex = '0;
			st_m = '0;
			st_wb = '0;
			exp_credit = 1'b0;
			started = 1'b1;
		end else begin
			do_pop = (queue.size() != 0) && !stall && !mem_wait;
			// mem_wait holds every stage
			if (!mem_wait) begin
				st_wb = flush ? 15'd0 : st_m;
				st_m = flush ? 15'd0 : st_ex;
				st_ex = do_pop ? queue.pop_front() : 15'd0;
			end
			exp_credit = do_pop;
			if (inst_valid) begin
				queue.push_back(exp_ctrl);
			end
		end
	end

	always @(negedge reset_n) begin
		if (started) begin
			ex_errors += mismatch("ex_alu_src_b", {1'b0, ex_alu_src_b}, {1'b0, st_ex[14]});
			ex_errors += mismatch("ex_alu_op", {1'b0, ex_alu_op}, {1'b0, st_ex[13]});
			m_errors += mismatch("m_mem_read", {1'b0, m_mem_read}, {1'b0, st_m[12]});
			m_errors += mismatch("m_mem_write", {1'b0, m_mem_write}, {1'b0, st_m[11]});
			m_errors += mismatch("m_pc_br", {1'b0, m_pc_br}, {1'b0, st_m[10]});
			m_errors += mismatch("m_pc_j", {1'b0, m_pc_j}, {1'b0, st_m[9]});
			m_errors += mismatch("m_pc_jr", {1'b0, m_pc_jr}, {1'b0, st_m[8]});
			wb_errors += mismatch("wb_reg_write", {1'b0, wb_reg_write}, {1'b0, st_wb[7]});
			wb_errors += mismatch("wb_src", wb_src, st_wb[6:5]);
			wb_errors += mismatch("wb_dest", wb_dest, st_wb[4:3]);
			wb_errors += mismatch("wb_halt", {1'b0, wb_halt}, {1'b0, st_wb[2]});
			wb_errors += mismatch("wb_wwd", {1'b0, wb_wwd}, {1'b0, st_wb[1]});
			wb_errors += mismatch("wb_new_inst", {1'b0, wb_new_inst}, {1'b0, st_wb[0]});
			credit_errors += mismatch("credit_return", {1'b0, credit_return},
				{1'b0, exp_credit});
		end
	end

endmodule

/* verif/control_unit_assertions.sv */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module control_unit_assertions (
	input logic        reset_n,
	input logic        reset,
	input logic        inst_valid,
	input logic        pop,
	input logic        m_mem_read,
	input logic        m_mem_write,
	input logic        m_pc_j,
	input logic        m_pc_jr,
	input logic [15:0] all_outs
);
	// entries held in the queue, tracked from pushes and pops
	int occupancy = 0;

	always_ff @(posedge reset_n) begin
		if (reset) begin
			occupancy <= 0;
		end else begin
			occupancy <= occupancy + (inst_valid ? 1 : 0) - (pop ? 1 : 0);
		end
	end

	a_queue_depth: assert property (@(posedge reset_n) disable iff (reset)
		occupancy <= `CU_QUEUE_DEPTH)
		else $error("issue queue holds more entries than its depth");

	a_jr_is_jump: assert property (@(posedge reset_n) disable iff (reset)
		m_pc_jr |-> m_pc_j)
		else $error("register jump in M without the jump control");

	a_mem_onehot: assert property (@(posedge reset_n) disable iff (reset)
		!(m_mem_read && m_mem_write))
		else $error("memory read and write raised together in M");

	a_reset_quiet: assert property (@(posedge reset_n) reset |=> (all_outs == 16'd0))
		else $error("an output is nonzero while in reset");

endmodule

bind control_unit_top control_unit_assertions u_assertions (
	.reset_n(reset_n),
	.reset(reset),
	.inst_valid(inst_valid),
	.pop(pop),
	.m_mem_read(m_mem_read),
	.m_mem_write(m_mem_write),
	.m_pc_j(m_pc_j),
	.m_pc_jr(m_pc_jr),
	.all_outs({credit_return, ex_alu_src_b, ex_alu_op, m_mem_read, m_mem_write, m_pc_br,
		m_pc_j, m_pc_jr, wb_reg_write, wb_src, wb_dest, wb_halt, wb_wwd, wb_new_inst})
);

/* rtl/control_unit_top.sv */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module control_unit_top (
	input  logic                     reset_n,
	input  logic                     reset,
	input  logic                     inst_valid,
	input  logic [`CU_WORD_SIZE-1:0] inst_in,
	input  logic                     stall,
	input  logic                     flush,
	input  logic                     mem_wait,
	output logic                     credit_return,
	output logic                     ex_alu_src_b,
	output logic                     ex_alu_op,
	output logic                     m_mem_read,
	output logic                     m_mem_write,
	output logic                     m_pc_br,
	output logic                     m_pc_j,
	output logic                     m_pc_jr,
	output logic                     wb_reg_write,
	output logic [1:0]               wb_src,
	output logic [1:0]               wb_dest,
	output logic                     wb_halt,
	output logic                     wb_wwd,
	output logic                     wb_new_inst
);
	isa_pkg::inst_word_t head_inst;
	logic head_valid;
	logic pop;
	logic head_nop;
	logic d_alu_src_b;
	logic d_alu_op;
	logic d_mem_read;
	logic d_mem_write;
	logic d_pc_br;
	logic d_pc_j;
	logic d_pc_jr;
	logic d_reg_write;
	logic [1:0] d_wb_src;
	logic [1:0] d_dest;
	logic d_halt;
	logic d_wwd;

	// issue whenever a word waits and the hazard unit lets it go
	assign pop = head_valid && !stall && !mem_wait;
	// a nop issues but never retires as a new instruction
	assign head_nop = (head_inst == isa_pkg::INST_NOP);

	inst_issue_queue u_queue (
		.reset_n(reset_n), .reset(reset), .inst_valid(inst_valid), .inst_in(inst_in),
		.pop(pop), .head_inst(head_inst), .head_valid(head_valid),
		.credit_return(credit_return)
	);

	ex_ctrl_decode u_ex_dec (.inst(head_inst), .alu_src_b(d_alu_src_b), .alu_op(d_alu_op));

	mem_ctrl_decode u_mem_dec (
		.inst(head_inst), .mem_read(d_mem_read), .mem_write(d_mem_write),
		.pc_br(d_pc_br), .pc_j(d_pc_j), .pc_jr(d_pc_jr)
	);

	wb_ctrl_decode u_wb_dec (
		.inst(head_inst), .reg_write(d_reg_write), .wb_src(d_wb_src),
		.dest(d_dest), .halt(d_halt), .wwd(d_wwd)
	);

	ctrl_pipe u_pipe (
		.reset_n(reset_n), .reset(reset), .issue(pop), .stall(stall), .flush(flush),
		.mem_wait(mem_wait), .id_nop(head_nop),
		.id_alu_src_b(d_alu_src_b), .id_alu_op(d_alu_op),
		.id_mem_read(d_mem_read), .id_mem_write(d_mem_write), .id_pc_br(d_pc_br),
		.id_pc_j(d_pc_j), .id_pc_jr(d_pc_jr), .id_reg_write(d_reg_write),
		.id_wb_src(d_wb_src), .id_dest(d_dest), .id_halt(d_halt), .id_wwd(d_wwd),
		.ex_alu_src_b(ex_alu_src_b), .ex_alu_op(ex_alu_op),
		.m_mem_read(m_mem_read), .m_mem_write(m_mem_write), .m_pc_br(m_pc_br),
		.m_pc_j(m_pc_j), .m_pc_jr(m_pc_jr), .wb_reg_write(wb_reg_write),
		.wb_src(wb_src), .wb_dest(wb_dest), .wb_halt(wb_halt), .wb_wwd(wb_wwd),
		.wb_new_inst(wb_new_inst)
	);

endmodule

/* rtl/ctrl_pipe.sv */
`timescale 1ns/1ps

module ctrl_pipe (
	input  logic       reset_n,
	input  logic       reset,
	input  logic       issue,
	input  logic       stall,
	input  logic       flush,
	input  logic       mem_wait,
	input  logic       id_nop,
	input  logic       id_alu_src_b,
	input  logic       id_alu_op,
	input  logic       id_mem_read,
	input  logic       id_mem_write,
	input  logic       id_pc_br,
	input  logic       id_pc_j,
	input  logic       id_pc_jr,
	input  logic       id_reg_write,
	input  logic [1:0] id_wb_src,
	input  logic [1:0] id_dest,
	input  logic       id_halt,
	input  logic       id_wwd,
	output logic       ex_alu_src_b,
	output logic       ex_alu_op,
	output logic       m_mem_read,
	output logic       m_mem_write,
	output logic       m_pc_br,
	output logic       m_pc_j,
	output logic       m_pc_jr,
	output logic       wb_reg_write,
	output logic [1:0] wb_src,
	output logic [1:0] wb_dest,
	output logic       wb_halt,
	output logic       wb_wwd,
	output logic       wb_new_inst
);
	// groups riding ahead of their own stage
	logic [4:0] ex_mem_grp;
	logic [6:0] ex_wb_grp;
	logic       ex_valid;
	logic [6:0] m_wb_grp;
	logic       m_valid;
	logic       take;

	// an empty queue or a stall leaves a bubble in EX
	assign take = issue && !stall;

	always_ff @(posedge reset_n) begin
		if (reset) begin
			{ex_alu_src_b, ex_alu_op, ex_mem_grp, ex_wb_grp, ex_valid} <= '0;
			{m_mem_read, m_mem_write, m_pc_br, m_pc_j, m_pc_jr} <= '0;
			{m_wb_grp, m_valid} <= '0;
			{wb_reg_write, wb_src, wb_dest, wb_halt, wb_wwd, wb_new_inst} <= '0;
		end else if (!mem_wait) begin
			if (take) begin
				{ex_alu_src_b, ex_alu_op} <= {id_alu_src_b, id_alu_op};
				ex_mem_grp <= {id_mem_read, id_mem_write, id_pc_br, id_pc_j, id_pc_jr};
				ex_wb_grp <= {id_reg_write, id_wb_src, id_dest, id_halt, id_wwd};
				ex_valid <= !id_nop;
			end else begin
				{ex_alu_src_b, ex_alu_op, ex_mem_grp, ex_wb_grp, ex_valid} <= '0;
			end

			// flush kills what leaves EX and M, the new EX entry stays
			if (flush) begin
				{m_mem_read, m_mem_write, m_pc_br, m_pc_j, m_pc_jr} <= '0;
				{m_wb_grp, m_valid} <= '0;
				{wb_reg_write, wb_src, wb_dest, wb_halt, wb_wwd, wb_new_inst} <= '0;
			end else begin
				{m_mem_read, m_mem_write, m_pc_br, m_pc_j, m_pc_jr} <= ex_mem_grp;
				{m_wb_grp, m_valid} <= {ex_wb_grp, ex_valid};
				{wb_reg_write, wb_src, wb_dest, wb_halt, wb_wwd} <= m_wb_grp;
				wb_new_inst <= m_valid;
			end
		end
	end

endmodule

/* rtl/wb_ctrl_decode.sv */
`timescale 1ns/1ps

module wb_ctrl_decode (
	input  isa_pkg::inst_word_t inst,
	output logic                reg_write,
	output logic [1:0]          wb_src,
	output logic [1:0]          dest,
	output logic                halt,
	output logic                wwd
);
	logic is_rgrp;
	logic rgrp_alu;
	logic is_jrl;

	assign is_rgrp = (inst.r.opcode == isa_pkg::OP_ALU);
	assign rgrp_alu = is_rgrp && (inst.r.func <= isa_pkg::FN_SHR);
	assign is_jrl = is_rgrp && (inst.r.func == isa_pkg::FN_JRL);

	always_comb begin
		reg_write = 1'b0;
		wb_src = ctrl_pkg::WB_SRC_ALU;
		dest = 2'd0;

		if (rgrp_alu) begin
			reg_write = 1'b1;
			dest = inst.r.rd;
		end else if (is_jrl || inst.i.opcode == isa_pkg::OP_JAL) begin
			reg_write = 1'b1;
			wb_src = ctrl_pkg::WB_SRC_PC;
			dest = ctrl_pkg::LINK_REG;
		end else begin
			case (inst.i.opcode)
				isa_pkg::OP_ADI,
				isa_pkg::OP_ORI: begin
					reg_write = 1'b1;
					dest = inst.i.rt;
				end
				isa_pkg::OP_LHI: begin
					reg_write = 1'b1;
					wb_src = ctrl_pkg::WB_SRC_LHI;
					dest = inst.i.rt;
				end
				isa_pkg::OP_LWD: begin
					reg_write = 1'b1;
					wb_src = ctrl_pkg::WB_SRC_MEM;
					dest = inst.i.rt;
				end
				default: reg_write = 1'b0;
			endcase
		end

		halt = is_rgrp && (inst.r.func == isa_pkg::FN_HLT);
		wwd = is_rgrp && (inst.r.func == isa_pkg::FN_WWD);
	end

endmodule

/* rtl/mem_ctrl_decode.sv */
`timescale 1ns/1ps

module mem_ctrl_decode (
	input  isa_pkg::inst_word_t inst,
	output logic                mem_read,
	output logic                mem_write,
	output logic                pc_br,
	output logic                pc_j,
	output logic                pc_jr
);
	logic is_nop;
	logic is_rgrp;
	logic is_jreg;

	// the all-zero word shares its opcode with bne
	assign is_nop = (inst == isa_pkg::INST_NOP);
	assign is_rgrp = (inst.r.opcode == isa_pkg::OP_ALU);
	assign is_jreg = is_rgrp &&
		(inst.r.func == isa_pkg::FN_JPR || inst.r.func == isa_pkg::FN_JRL);

	always_comb begin
		mem_read = (inst.i.opcode == isa_pkg::OP_LWD);
		mem_write = (inst.i.opcode == isa_pkg::OP_SWD);

		case (inst.i.opcode)
			isa_pkg::OP_BNE,
			isa_pkg::OP_BEQ,
			isa_pkg::OP_BGZ,
			isa_pkg::OP_BLZ: pc_br = !is_nop;
			default: pc_br = 1'b0;
		endcase

		pc_j = is_jreg || inst.i.opcode == isa_pkg::OP_JMP ||
			inst.i.opcode == isa_pkg::OP_JAL;
		// register target jumps
		pc_jr = is_jreg;
	end

endmodule

/* rtl/ex_ctrl_decode.sv */
`timescale 1ns/1ps

module ex_ctrl_decode (
	input  isa_pkg::inst_word_t inst,
	output logic                alu_src_b,
	output logic                alu_op
);

	always_comb begin
		// immediate operand forms, beq and bne compare two registers
		case (inst.i.opcode)
			isa_pkg::OP_ADI,
			isa_pkg::OP_ORI,
			isa_pkg::OP_LHI,
			isa_pkg::OP_LWD,
			isa_pkg::OP_SWD,
			isa_pkg::OP_BGZ,
			isa_pkg::OP_BLZ: alu_src_b = 1'b1;
			default: alu_src_b = 1'b0;
		endcase

		// R group with a real alu function only
		alu_op = (inst.r.opcode == isa_pkg::OP_ALU) && (inst.r.func <= isa_pkg::FN_SHR);
	end

endmodule

/* rtl/inst_issue_queue.sv */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module inst_issue_queue (
	input  logic                     reset_n,
	input  logic                     reset,
	input  logic                     inst_valid,
	input  logic [`CU_WORD_SIZE-1:0] inst_in,
	input  logic                     pop,
	output isa_pkg::inst_word_t      head_inst,
	output logic                     head_valid,
	output logic                     credit_return
);
	localparam int DEPTH = `CU_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`CU_WORD_SIZE-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	// wrap at depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_inst = mem[rd_ptr];
	assign do_pop = pop && head_valid;

	always_ff @(posedge reset_n) begin
		if (inst_valid) begin
			mem[wr_ptr] <= inst_in;
		end
	end

	always_ff @(posedge reset_n) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (inst_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// simultaneous push and pop leaves the count alone
			case ({inst_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per popped entry
			credit_return <= do_pop;
		end
	end

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

	// write-back data source select
	localparam logic [1:0] WB_SRC_ALU = 2'd0;
	localparam logic [1:0] WB_SRC_MEM = 2'd1;
	localparam logic [1:0] WB_SRC_PC  = 2'd2;
	localparam logic [1:0] WB_SRC_LHI = 2'd3;

	// return address register of jal and jrl
	localparam logic [1:0] LINK_REG = 2'd2;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

	// opcodes
	localparam logic [3:0] OP_BNE = 4'd0;
	localparam logic [3:0] OP_BEQ = 4'd1;
	localparam logic [3:0] OP_BGZ = 4'd2;
	localparam logic [3:0] OP_BLZ = 4'd3;
	localparam logic [3:0] OP_ADI = 4'd4;
	localparam logic [3:0] OP_ORI = 4'd5;
	localparam logic [3:0] OP_LHI = 4'd6;
	localparam logic [3:0] OP_LWD = 4'd7;
	localparam logic [3:0] OP_SWD = 4'd8;
	localparam logic [3:0] OP_JMP = 4'd9;
	localparam logic [3:0] OP_JAL = 4'd10;
	// R group, also carries jpr, jrl, hlt and wwd
	localparam logic [3:0] OP_ALU = 4'd15;

	// function codes of the R group
	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_AND = 6'd2;
	localparam logic [5:0] FN_ORR = 6'd3;
	localparam logic [5:0] FN_NOT = 6'd4;
	localparam logic [5:0] FN_TCP = 6'd5;
	localparam logic [5:0] FN_SHL = 6'd6;
	localparam logic [5:0] FN_SHR = 6'd7;
	localparam logic [5:0] FN_JPR = 6'd25;
	localparam logic [5:0] FN_JRL = 6'd26;
	localparam logic [5:0] FN_WWD = 6'd28;
	localparam logic [5:0] FN_HLT = 6'd29;

	localparam logic [15:0] INST_NOP = 16'h0000;

	// one word, read as R form or I form
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			logic [5:0] func;
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} i;
	} inst_word_t;

endpackage

/* include/cu_cfg.svh */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// instruction word width
`define CU_WORD_SIZE 16

// issue queue entries, also the credits granted after reset
`define CU_QUEUE_DEPTH 4

// sender credit counter width
`define CU_CREDIT_W 3

`endif
